//--- main_defs.svh
`ifndef MAIN_DEFS_SVH
`define MAIN_DEFS_SVH

// board type codes
`define MAIN_HW_NINJAKUN 2'd0
`define MAIN_HW_RAIDERS5 2'd2

// shared RAM is 2 KB, split into two banks by address bit 10
`define MAIN_SHMEM_AW 11

// CPU address map
`define MAIN_ROM_TOP 16'h7FFF
`define MAIN_IN_BASE 16'hA000
`define MAIN_SH_BASE 16'hE000

`endif

//--- main_bus_pkg.sv
`default_nettype none

package main_bus_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;
	typedef logic [14:0] rom_addr_t;

	// one APB port, requester to completer
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		cpu_addr_t paddr;
		cpu_data_t pwdata;
	} apb_req_t;

	// completer back to requester
	typedef struct packed {
		cpu_data_t prdata;
		logic pready;
	} apb_rsp_t;

	// external bus owner FSM
	typedef enum logic [1:0] {
		idle,
		setup,
		access0,
		access1
	} mux_state_t;

endpackage

`default_nettype wire

//--- main_io_pkg.sv
`default_nettype none

package main_io_pkg;

	typedef logic [1:0] hw_type_t;

	// control panel byte, active low
	typedef logic [7:0] panel_t;

	// screen flip / lock bits, written from data bits 7:6
	typedef logic [1:0] flip_t;

	// exactly one region per access
	typedef struct packed {
		logic rom;
		logic inp;
		logic shm;
		logic ext;
	} region_sel_t;

endpackage

`default_nettype wire

//--- main_irqgen.sv
`default_nettype none
`timescale 1ns/10ps

module main_irqgen (
	input  wire logic mclk,
	input  wire logic arst_n,
	input  wire logic vblk,
	input  wire logic irq0_ack,
	input  wire logic irq1_ack,
	output logic      irq0,
	output logic      irq1
);

	logic       vblk_q;
	logic       vblk_rise;
	logic [1:0] ack;
	logic [1:0] req;

	assign vblk_rise = vblk & ~vblk_q;
	assign ack = {irq1_ack, irq0_ack};

	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			vblk_q <= 1'b0;
			req <= 2'b00;
		end else begin
			vblk_q <= vblk;
			// ack beats a new edge in the same cycle
			req <= (req | {2{vblk_rise}}) & ~ack;
		end
	end

	assign irq0 = req[0];
	assign irq1 = req[1];

	property p_held_until_ack(logic r, logic a);
		@(posedge mclk) disable iff (!arst_n)
		$fell(r) |-> $past(a);
	endproperty

	a_irq0_held: assert property (p_held_until_ack(req[0], ack[0]))
		else $fatal(1, "[ERROR] irq0 dropped without irq0_ack");

	a_irq1_held: assert property (p_held_until_ack(req[1], ack[1]))
		else $fatal(1, "[ERROR] irq1 dropped without irq1_ack");

endmodule

`default_nettype wire

//--- main_adec.sv
`default_nettype none
`timescale 1ns/10ps

`include "main_defs.svh"

module main_adec
	import main_bus_pkg::*, main_io_pkg::*;
(
	input  wire logic        mclk,
	input  wire logic        cpu0_psel,
	input  wire logic        cpu1_psel,
	input  wire cpu_addr_t   cpu0_addr,
	input  wire cpu_addr_t   cpu1_addr,
	output region_sel_t      sel0,
	output region_sel_t      sel1
);

	localparam cpu_addr_t rom_top = `MAIN_ROM_TOP;
	localparam cpu_addr_t in_base = `MAIN_IN_BASE;
	localparam cpu_addr_t sh_base = `MAIN_SH_BASE;

	function automatic region_sel_t decode(input cpu_addr_t addr);
		region_sel_t sel;
		sel = '0;
		if (addr <= rom_top) begin
			sel.rom = 1'b1;
		end else if (addr[15:2] == in_base[15:2]) begin
			// four input registers
			sel.inp = 1'b1;
		end else if (addr[15:`MAIN_SHMEM_AW] == sh_base[15:`MAIN_SHMEM_AW]) begin
			sel.shm = 1'b1;
		end else begin
			// everything else leaves the board
			sel.ext = 1'b1;
		end
		return sel;
	endfunction

	assign sel0 = decode(cpu0_addr);
	assign sel1 = decode(cpu1_addr);

	a_sel0_onehot: assert property (@(posedge mclk) cpu0_psel |-> $onehot(sel0))
		else $fatal(1, "[ERROR] sel0 not one-hot, sel0=%h addr=%h", sel0, cpu0_addr);

	a_sel1_onehot: assert property (@(posedge mclk) cpu1_psel |-> $onehot(sel1))
		else $fatal(1, "[ERROR] sel1 not one-hot, sel1=%h addr=%h", sel1, cpu1_addr);

endmodule

`default_nettype wire

//--- main_shmem.sv
`default_nettype none
`timescale 1ns/10ps

`include "main_defs.svh"

module main_shmem
	import main_bus_pkg::*, main_io_pkg::*;
(
	input  wire logic      mclk,
	input  wire hw_type_t  hw_type,
	input  wire logic      we0,
	input  wire cpu_addr_t addr0,
	input  wire cpu_data_t wdata0,
	output cpu_data_t      rdata0,
	input  wire logic      we1,
	input  wire cpu_addr_t addr1,
	input  wire cpu_data_t wdata1,
	output cpu_data_t      rdata1
);

	localparam int depth = 1 << `MAIN_SHMEM_AW;

	cpu_data_t                 mem [depth];
	logic [`MAIN_SHMEM_AW-1:0] wa0;
	logic [`MAIN_SHMEM_AW-1:0] wa1;
	logic                      bank1;

	// cpu 1 sees the banks swapped on ninjakun
	assign bank1 = (hw_type == `MAIN_HW_NINJAKUN) ? ~addr1[`MAIN_SHMEM_AW-1]
	                                               : addr1[`MAIN_SHMEM_AW-1];

	assign wa0 = addr0[`MAIN_SHMEM_AW-1:0];
	assign wa1 = {bank1, addr1[`MAIN_SHMEM_AW-2:0]};

	always_ff @(posedge mclk) begin
		if (we0)
			mem[wa0] <= wdata0;
		if (we1)
			mem[wa1] <= wdata1;
		rdata0 <= mem[wa0];
		rdata1 <= mem[wa1];
	end

	a_no_collision: assert property (@(posedge mclk) !(we0 && we1 && wa0 == wa1))
		else $fatal(1, "[ERROR] shmem write collision, wa0=%h wa1=%h", wa0, wa1);

endmodule

`default_nettype wire

//--- main_input.sv
`default_nettype none
`timescale 1ns/10ps

module main_input
	import main_bus_pkg::*, main_io_pkg::*;
(
	input  wire logic      mclk,
	input  wire logic      arst_n,
	input  wire hw_type_t  hw_type,
	input  wire panel_t    ctr1,
	input  wire panel_t    ctr2,
	input  wire panel_t    ctr3,
	input  wire logic      vblk,
	input  wire cpu_addr_t addr0,
	input  wire logic      wr0,
	input  wire cpu_data_t wdata0,
	input  wire cpu_addr_t addr1,
	input  wire logic      wr1,
	input  wire cpu_data_t wdata1,
	output cpu_data_t      inpd0,
	output cpu_data_t      inpd1
);

	flip_t      flip0;
	flip_t      flip1;
	logic [1:0] idx0;
	logic [1:0] idx1;

	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			flip0 <= '0;
			flip1 <= '0;
		end else begin
			if (wr0)
				flip0 <= wdata0[7:6];
			if (wr1)
				flip1 <= wdata1[7:6];
		end
	end

	// later boards wire cpu 0 index bit 1 to A3
	assign idx0 = hw_type[1] ? {addr0[3], addr0[0]} : addr0[1:0];
	assign idx1 = addr1[1:0];

	function automatic cpu_data_t read_byte(input logic [1:0] idx, input flip_t flip);
		cpu_data_t d;
		case (idx)
			2'd0: d = ~ctr1;
			2'd1: d = ~ctr2;
			2'd2: d = ~ctr3;
			default: d = {flip, 5'b00000, vblk};
		endcase
		return d;
	endfunction

	assign inpd0 = read_byte(idx0, flip0);
	assign inpd1 = read_byte(idx1, flip1);

endmodule

`default_nettype wire

//--- main_cpumux.sv
`default_nettype none
`timescale 1ns/10ps

module main_cpumux
	import main_bus_pkg::*;
(
	input  wire logic     mclk,
	input  wire logic     arst_n,
	input  wire apb_req_t req0,
	input  wire logic     sel0_ext,
	input  wire apb_req_t req1,
	input  wire logic     sel1_ext,
	output apb_req_t      ext_req,
	input  wire apb_rsp_t ext_rsp,
	output logic          done0,
	output logic          done1,
	output cpu_data_t     rdata
);

	mux_state_t state;
	mux_state_t state_nx;
	logic       last1;
	logic [1:0] done_q;
	logic       want0;
	logic       want1;
	logic       pick1;
	logic       granting;
	logic       finishing;
	apb_req_t   hold;

	// a cpu that finishes this cycle is not asking again yet
	assign want0 = req0.psel & sel0_ext & ~done_q[0];
	assign want1 = req1.psel & sel1_ext & ~done_q[1];
	assign pick1 = want1 & (~want0 | ~last1);

	assign granting = (state == idle) && (want0 || want1);
	assign finishing = (state == access0 || state == access1) && ext_rsp.pready;

	always_comb begin
		state_nx = state;
		case (state)
			idle: if (want0 || want1) state_nx = setup;
			setup: state_nx = last1 ? access1 : access0;
			default: if (ext_rsp.pready) state_nx = idle;
		endcase
	end

	always_ff @(posedge mclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			last1 <= 1'b1;
			done_q <= 2'b00;
		end else begin
			state <= state_nx;
			done_q <= 2'b00;
			if (granting)
				last1 <= pick1;
			if (finishing)
				done_q[last1] <= 1'b1;
		end
	end

	always_ff @(posedge mclk) begin
		if (granting)
			hold <= pick1 ? req1 : req0;
		if (finishing)
			rdata <= ext_rsp.prdata;
	end

	always_comb begin
		ext_req = hold;
		ext_req.psel = (state != idle);
		ext_req.penable = (state == access0) || (state == access1);
	end

	assign done0 = done_q[0];
	assign done1 = done_q[1];

	a_ext_hold: assert property (@(posedge mclk) disable iff (!arst_n)
		(ext_req.penable && !ext_rsp.pready) |=> $stable(ext_req))
		else $fatal(1, "[ERROR] ext_req changed while waiting, ext_req=%h", ext_req);

	a_one_done: assert property (@(posedge mclk) disable iff (!arst_n) !(done0 && done1))
		else $fatal(1, "[ERROR] done0 and done1 both high, done=%h", done_q);

endmodule

`default_nettype wire

//--- main_board.sv
`default_nettype none
`timescale 1ns/10ps

module main_board
	import main_bus_pkg::*, main_io_pkg::*;
(
	input  wire logic      mclk,
	input  wire logic      arst_n,
	input  wire hw_type_t  hw_type,
	input  wire logic      vblk,
	input  wire panel_t    ctr1,
	input  wire panel_t    ctr2,
	input  wire panel_t    ctr3,
	input  wire apb_req_t  cpu0_req,
	output apb_rsp_t       cpu0_rsp,
	input  wire apb_req_t  cpu1_req,
	output apb_rsp_t       cpu1_rsp,
	output logic           irq0,
	output logic           irq1,
	input  wire logic      irq0_ack,
	input  wire logic      irq1_ack,
	output rom_addr_t      rom0_addr,
	input  wire cpu_data_t rom0_data,
	output rom_addr_t      rom1_addr,
	input  wire cpu_data_t rom1_data,
	output apb_req_t       ext_req,
	input  wire apb_rsp_t  ext_rsp
);

	region_sel_t sel0, sel1;
	cpu_data_t   shdt0, shdt1, inpd0, inpd1, ext_rdata;
	logic        done0, done1;
	logic        acc_wr0, acc_wr1;

	assign acc_wr0 = cpu0_req.psel & cpu0_req.penable & cpu0_req.pwrite;
	assign acc_wr1 = cpu1_req.psel & cpu1_req.penable & cpu1_req.pwrite;

	assign rom0_addr = cpu0_req.paddr[14:0];
	assign rom1_addr = cpu1_req.paddr[14:0];

	main_irqgen u_irqgen (.mclk(mclk), .arst_n(arst_n), .vblk(vblk),
		.irq0_ack(irq0_ack), .irq1_ack(irq1_ack), .irq0(irq0), .irq1(irq1));

	main_adec u_adec (.mclk(mclk), .cpu0_psel(cpu0_req.psel), .cpu1_psel(cpu1_req.psel),
		.cpu0_addr(cpu0_req.paddr), .cpu1_addr(cpu1_req.paddr), .sel0(sel0), .sel1(sel1));

	main_shmem u_shmem (.mclk(mclk), .hw_type(hw_type),
		.we0(acc_wr0 & sel0.shm), .addr0(cpu0_req.paddr), .wdata0(cpu0_req.pwdata), .rdata0(shdt0),
		.we1(acc_wr1 & sel1.shm), .addr1(cpu1_req.paddr), .wdata1(cpu1_req.pwdata), .rdata1(shdt1));

	main_input u_input (.mclk(mclk), .arst_n(arst_n), .hw_type(hw_type),
		.ctr1(ctr1), .ctr2(ctr2), .ctr3(ctr3), .vblk(vblk),
		.addr0(cpu0_req.paddr), .wr0(acc_wr0 & sel0.inp), .wdata0(cpu0_req.pwdata),
		.addr1(cpu1_req.paddr), .wr1(acc_wr1 & sel1.inp), .wdata1(cpu1_req.pwdata),
		.inpd0(inpd0), .inpd1(inpd1));

	main_cpumux u_cpumux (.mclk(mclk), .arst_n(arst_n),
		.req0(cpu0_req), .sel0_ext(sel0.ext), .req1(cpu1_req), .sel1_ext(sel1.ext),
		.ext_req(ext_req), .ext_rsp(ext_rsp), .done0(done0), .done1(done1), .rdata(ext_rdata));

	// local regions finish on the first access cycle, ext waits for the mux
	function automatic apb_rsp_t form_rsp(input apb_req_t req, input region_sel_t sel,
		input cpu_data_t rom_d, input cpu_data_t inp_d, input cpu_data_t sh_d,
		input logic done);
		apb_rsp_t rsp;
		logic     local_hit;
		local_hit = sel.rom | sel.inp | sel.shm;
		rsp.pready = req.psel & req.penable & (local_hit | (sel.ext & done));
		if (sel.inp)
			rsp.prdata = inp_d;
		else if (sel.shm)
			rsp.prdata = sh_d;
		else if (sel.ext)
			rsp.prdata = ext_rdata;
		else
			rsp.prdata = rom_d;
		return rsp;
	endfunction

	assign cpu0_rsp = form_rsp(cpu0_req, sel0, rom0_data, inpd0, shdt0, done0);
	assign cpu1_rsp = form_rsp(cpu1_req, sel1, rom1_data, inpd1, shdt1, done1);

endmodule

`default_nettype wire

//--- tb_main.sv
`default_nettype none
`timescale 1ns/10ps

`include "main_defs.svh"

module tb_main
	import main_bus_pkg::*, main_io_pkg::*;
();

	logic        mclk;
	logic        arst_n;
	hw_type_t    hw_type;
	logic        vblk;
	panel_t      ctr1, ctr2, ctr3;
	apb_req_t    cpu0_req, cpu1_req;
	apb_rsp_t    cpu0_rsp, cpu1_rsp;
	logic        irq0, irq1, irq0_ack, irq1_ack;
	rom_addr_t   rom0_addr, rom1_addr;
	cpu_data_t   rom0_data, rom1_data;
	apb_req_t    ext_req;
	apb_rsp_t    ext_rsp = '0;
	apb_req_t    ext_cur;
	apb_req_t    ext_log[$];
	int          ext_wait;
	int          cycles = 0;
	logic [31:0] rng = 32'h5f058b3e;
	logic [31:0] rng_ext = 32'h5f058b3e;

	main_board dut (.mclk(mclk), .arst_n(arst_n), .hw_type(hw_type), .vblk(vblk),
		.ctr1(ctr1), .ctr2(ctr2), .ctr3(ctr3), .cpu0_req(cpu0_req), .cpu0_rsp(cpu0_rsp),
		.cpu1_req(cpu1_req), .cpu1_rsp(cpu1_rsp), .irq0(irq0), .irq1(irq1),
		.irq0_ack(irq0_ack), .irq1_ack(irq1_ack), .rom0_addr(rom0_addr), .rom0_data(rom0_data),
		.rom1_addr(rom1_addr), .rom1_data(rom1_data), .ext_req(ext_req), .ext_rsp(ext_rsp));

	initial mclk = 1'b0;
	always #50 mclk = ~mclk;

	// program ROM models
	assign rom0_data = rom0_addr[7:0] ^ 8'h5A;
	assign rom1_data = rom1_addr[7:0] ^ 8'hA5;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			report_fail($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic is_local(input cpu_addr_t a);
		return a <= `MAIN_ROM_TOP || (a >= `MAIN_IN_BASE && a <= `MAIN_IN_BASE + 16'd3) ||
			(a >= `MAIN_SH_BASE && a <= `MAIN_SH_BASE + 16'h07FF);
	endfunction

	// input byte as seen by a cpu, from the register map
	function automatic cpu_data_t exp_inp(input int cpu, input hw_type_t h, input cpu_addr_t a,
		input flip_t f);
		logic [1:0] idx;
		idx = (cpu == 0 && h[1]) ? {a[3], a[0]} : a[1:0];
		case (idx)
			2'd0: return ~ctr1;
			2'd1: return ~ctr2;
			2'd2: return ~ctr3;
			default: return {f, 5'b00000, vblk};
		endcase
	endfunction

	task automatic put_req(input int cpu, input apb_req_t r);
		if (cpu == 0)
			cpu0_req = r;
		else
			cpu1_req = r;
	endtask

	// one APB transfer, called 1 ns after a rising edge
	task automatic apb_access(input int cpu, input logic wr, input cpu_addr_t addr,
		input cpu_data_t wd, output cpu_data_t rd, output int waits);
		apb_req_t r;
		apb_rsp_t rsp;
		logic     fin;
		r = '0;
		r.psel = 1'b1;
		r.pwrite = wr;
		r.paddr = addr;
		r.pwdata = wd;
		put_req(cpu, r);
		@(posedge mclk);
		#1;
		r.penable = 1'b1;
		put_req(cpu, r);
		waits = 0;
		fin = 1'b0;
		while (!fin) begin
			@(negedge mclk);
			rsp = (cpu == 0) ? cpu0_rsp : cpu1_rsp;
			if (rsp.pready) begin
				fin = 1'b1;
			end else begin
				waits++;
				if (waits > 500)
					report_fail($sformatf("cpu %0d transfer at %h never completed", cpu, addr));
				@(posedge mclk);
				#1;
			end
		end
		rd = rsp.prdata;
		@(posedge mclk);
		#1;
		put_req(cpu, '0);
	endtask

	// external completer with random wait states
	always begin
		@(posedge mclk);
		#1;
		if (!arst_n) begin
			ext_rsp = '0;
		end else if (ext_rsp.pready) begin
			ext_log.push_back(ext_cur);
			ext_rsp = '0;
		end else if (ext_req.psel && !ext_req.penable) begin
			rng_ext = lcg_next(rng_ext);
			ext_wait = int'(rng_ext[17:16]);
		end else if (ext_req.psel && ext_req.penable) begin
			if (ext_wait == 0) begin
				ext_cur = ext_req;
				ext_rsp.prdata = ~ext_req.paddr[7:0];
				ext_rsp.pready = 1'b1;
			end else begin
				ext_wait--;
			end
		end
	end

	always @(posedge mclk) begin
		cycles++;
		if (cycles >= 20000)
			report_fail("timeout, the run went past 20000 cycles");
	end

	a_local0: assert property (@(posedge mclk) disable iff (!arst_n)
		(cpu0_req.psel && cpu0_req.penable && is_local(cpu0_req.paddr)) |-> cpu0_rsp.pready)
		else report_fail($sformatf("[ERROR] cpu0_rsp.pready low on local access, paddr=%h",
			cpu0_req.paddr));
	a_local1: assert property (@(posedge mclk) disable iff (!arst_n)
		(cpu1_req.psel && cpu1_req.penable && is_local(cpu1_req.paddr)) |-> cpu1_rsp.pready)
		else report_fail($sformatf("[ERROR] cpu1_rsp.pready low on local access, paddr=%h",
			cpu1_req.paddr));
	a_ext_stable: assert property (@(posedge mclk) disable iff (!arst_n)
		(ext_req.psel && ext_req.penable && !ext_rsp.pready) |=> $stable(ext_req))
		else report_fail($sformatf("[ERROR] ext_req moved under back-pressure, ext_req=%h",
			ext_req));
	a_irq0: assert property (@(posedge mclk) disable iff (!arst_n) $fell(irq0) |-> $past(irq0_ack))
		else report_fail("[ERROR] irq0 fell without irq0_ack, irq0=0 irq0_ack=0");
	a_irq1: assert property (@(posedge mclk) disable iff (!arst_n) $fell(irq1) |-> $past(irq1_ack))
		else report_fail("[ERROR] irq1 fell without irq1_ack, irq1=0 irq1_ack=0");

	initial begin
		cpu_data_t rd0, rd1, d0, d1;
		cpu_addr_t a0, a1, a_solo;
		int        n0, n1;
		logic      w0, w1, owner, prev_owner;
		hw_type_t  h;
		arst_n = 1'b0;
		hw_type = `MAIN_HW_NINJAKUN;
		vblk = 1'b0;
		ctr1 = 8'hFE;
		ctr2 = 8'h3C;
		ctr3 = 8'h81;
		cpu0_req = '0;
		cpu1_req = '0;
		irq0_ack = 1'b0;
		irq1_ack = 1'b0;
		prev_owner = 1'b0;
		repeat (2) @(posedge mclk);
		#1;
		arst_n = 1'b1;
		check_hex("irq0", 16'(irq0), 16'h0);
		check_hex("ext_req.psel", 16'(ext_req.psel), 16'h0);
		check_hex("irq1", 16'(irq1), 16'h0);

		for (int i = 0; i < 8; i++) begin
			rng = lcg_next(rng);
			a0 = {1'b0, rng[14:0]};
			a1 = {1'b0, rng[30:16]};
			apb_access(0, 1'b0, a0, 8'h00, rd0, n0);
			check_hex("cpu0_rsp.prdata rom", 16'(rd0), 16'(a0[7:0] ^ 8'h5A));
			check_hex("cpu0 rom waits", 16'(n0), 16'h0);
			apb_access(1, 1'b0, a1, 8'h00, rd1, n1);
			check_hex("cpu1_rsp.prdata rom", 16'(rd1), 16'(a1[7:0] ^ 8'hA5));
			check_hex("cpu1 rom waits", 16'(n1), 16'h0);
		end

		for (int b = 0; b < 2; b++) begin
			h = (b == 0) ? `MAIN_HW_NINJAKUN : `MAIN_HW_RAIDERS5;
			hw_type = h;
			for (int i = 0; i < 4; i++) begin
				rng = lcg_next(rng);
				a0 = `MAIN_SH_BASE + {5'b0, i[0], rng[9:0]};
				d0 = rng[23:16];
				// cpu 1 sees bank bit 10 inverted on ninjakun
				a1 = (h == `MAIN_HW_NINJAKUN) ? (a0 ^ 16'h0400) : a0;
				apb_access(0, 1'b1, a0, d0, rd0, n0);
				apb_access(1, 1'b0, a1, 8'h00, rd1, n1);
				check_hex("cpu1_rsp.prdata shm", 16'(rd1), 16'(d0));
				apb_access(0, 1'b0, a0, 8'h00, rd0, n0);
				check_hex("cpu0_rsp.prdata shm", 16'(rd0), 16'(d0));
			end
		end

		for (int b = 0; b < 2; b++) begin
			h = (b == 0) ? `MAIN_HW_NINJAKUN : `MAIN_HW_RAIDERS5;
			hw_type = h;
			vblk = b[0];
			d0 = (b == 0) ? 8'h40 : 8'h80;
			apb_access(0, 1'b1, `MAIN_IN_BASE + 16'd3, d0, rd0, n0);
			apb_access(1, 1'b1, `MAIN_IN_BASE, 8'hC0, rd1, n1);
			for (int i = 0; i < 4; i++) begin
				a0 = `MAIN_IN_BASE + 16'(i);
				apb_access(0, 1'b0, a0, 8'h00, rd0, n0);
				check_hex("cpu0_rsp.prdata inp", 16'(rd0), 16'(exp_inp(0, h, a0, d0[7:6])));
				apb_access(1, 1'b0, a0, 8'h00, rd1, n1);
				check_hex("cpu1_rsp.prdata inp", 16'(rd1), 16'(exp_inp(1, h, a0, 2'b11)));
			end
		end

		// clear any request left from the input pass, then a fresh edge
		irq0_ack = 1'b1;
		irq1_ack = 1'b1;
		vblk = 1'b0;
		@(posedge mclk);
		#1;
		irq0_ack = 1'b0;
		irq1_ack = 1'b0;
		repeat (2) @(posedge mclk);
		#1;
		vblk = 1'b1;
		n0 = 0;
		while (!(irq0 && irq1)) begin
			n0++;
			if (n0 > 10)
				report_fail("irq0 and irq1 did not rise after a vblank edge");
			@(posedge mclk);
			#1;
		end
		repeat (5) @(posedge mclk);
		#1;
		irq0_ack = 1'b1;
		@(posedge mclk);
		#1;
		irq0_ack = 1'b0;
		check_hex("irq0", 16'(irq0), 16'h0);
		check_hex("irq1", 16'(irq1), 16'h1);
		irq1_ack = 1'b1;
		@(posedge mclk);
		#1;
		irq1_ack = 1'b0;
		check_hex("irq1", 16'(irq1), 16'h0);

		for (int k = 0; k < 6; k++) begin
			rng = lcg_next(rng);
			a0 = 16'h9000 + 16'(k);
			a1 = 16'hC800 + 16'(k);
			w0 = ~k[0];
			w1 = k[0];
			d0 = rng[7:0];
			d1 = rng[15:8];
			// last winner goes alone first and so becomes the cpu served last
			if (k > 0) begin
				a_solo = 16'hB000 + 16'(k);
				apb_access(int'(prev_owner), 1'b0, a_solo, 8'h00, rd0, n0);
				check_hex(prev_owner ? "cpu1_rsp.prdata ext" : "cpu0_rsp.prdata ext",
					16'(rd0), {8'h00, ~a_solo[7:0]});
			end
			ext_log.delete();
			fork
				apb_access(0, w0, a0, d0, rd0, n0);
				apb_access(1, w1, a1, d1, rd1, n1);
			join
			if (!w0)
				check_hex("cpu0_rsp.prdata ext", 16'(rd0), {8'h00, ~a0[7:0]});
			if (!w1)
				check_hex("cpu1_rsp.prdata ext", 16'(rd1), {8'h00, ~a1[7:0]});
			check_hex("ext transfer count", 16'(ext_log.size()), 16'h2);
			foreach (ext_log[j]) begin
				if (ext_log[j].paddr == a0) begin
					check_hex("ext_req.pwrite", 16'(ext_log[j].pwrite), 16'(w0));
					if (w0)
						check_hex("ext_req.pwdata", 16'(ext_log[j].pwdata), 16'(d0));
				end else if (ext_log[j].paddr == a1) begin
					check_hex("ext_req.pwrite", 16'(ext_log[j].pwrite), 16'(w1));
					if (w1)
						check_hex("ext_req.pwdata", 16'(ext_log[j].pwdata), 16'(d1));
				end else begin
					check_hex("ext_req.paddr", ext_log[j].paddr, a0);
				end
			end
			owner = (ext_log[0].paddr == a1);
			if (k > 0 && owner == prev_owner)
				report_fail("external bus arbitration did not alternate between the CPUs");
			prev_owner = owner;
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
main_bus_pkg.sv
main_io_pkg.sv
main_irqgen.sv
main_adec.sv
main_shmem.sv
main_input.sv
main_cpumux.sv
main_board.sv
tb_main.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the board testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_main -f src.f -o tb_main \
	> "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_main > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Regression failed" "$SIM_LOG"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "Regression passed" "$SIM_LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
